// File: hw/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data path and address width
`define CPU_DATA_W 32

// register file geometry
`define CPU_REG_AW 4
`define CPU_NUM_REGS 16

// first fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

// byte step between instruction words
`define CPU_PC_STEP 32'h0000_0004

// micro-step counter, wide enough for the longest
// evaluate sequence (ld.l)
`define CPU_SEQ_W 3

`endif

// File: hw/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef enum logic [1:0] {ST_FETCH, ST_EVAL, ST_HALT} state_e;

  typedef enum logic [1:0] {
    MODE_REG = 2'd0, MODE_REGIND = 2'd1, MODE_IMM = 2'd2, MODE_DIR = 2'd3
  } mode_e;

  typedef enum logic [2:0] {
    ALU_AND = 3'd0, ALU_OR, ALU_ADD, ALU_SUB, ALU_XOR, ALU_SHL, ALU_SHR, ALU_ASR
  } alu_op_e;

  typedef enum logic [6:0] {
    OP_NOP = 7'h00, OP_CMP = 7'h09, OP_MOV = 7'h0a, OP_COM = 7'h0b, OP_NEG = 7'h0c,
    OP_REG_ALU = 7'h20 // base of the 2x group
  } reg_op_e;

  typedef enum logic [6:0] {
    OP_BRA = 7'h0, OP_BEQ, OP_BNE, OP_BGTU, OP_BGT, OP_BGE, OP_BLE, OP_BLT,
    OP_BGEU, OP_BLTU, OP_BLEU, OP_BRN, OP_LDIU
  } imm_op_e;

  typedef enum logic [6:0] {OP_STL = 7'h0, OP_LDL = 7'h1} regind_op_e;

  typedef enum logic {A2_REG, A2_SIMM} alu2_sel_e;
  typedef enum logic [2:0] {RS_ALU, RS_MDR, RS_MOVB, RS_COMB, RS_NEGB, RS_UIMM} reg_sel_e;
  typedef enum logic [1:0] {PC_HOLD, PC_INC, PC_REL} pc_sel_e;
  typedef enum logic {MAR_HOLD, MAR_ALU} mar_sel_e;

  typedef struct packed {
    logic ltu; // unsigned op1 < op2
    logic lt;  // signed op1 < op2
    logic eq;
  } ccr_t;

  typedef struct packed {
    alu_op_e                alu_op;
    alu2_sel_e              alu2_sel;
    logic [`CPU_REG_AW-1:0] rd_addr1;
    logic [`CPU_REG_AW-1:0] rd_addr2;
    logic [`CPU_REG_AW-1:0] wr_addr;
    logic                   reg_write;
    reg_sel_e               reg_sel;
    mar_sel_e               mar_sel;
    logic                   mdr_load;
    pc_sel_e                pc_sel;
    logic                   addr_mar; // bus address from mar, else pc
    logic                   ir_write;
    logic                   ccr_write;
    logic                   bus_read;
    logic                   bus_write;
  } ctrl_t;

  typedef struct packed {
    logic [`CPU_DATA_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] wdata;
    logic                   read;
    logic                   write;
  } bus_req_t;

endpackage

// File: hw/cpu_control.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpu_control (
  input  logic           clock,
  input  logic           reset_n,
  input  logic [31:0]    ir,
  input  cpu_pkg::ccr_t  ccr,
  input  logic           bus_wait,
  output cpu_pkg::ctrl_t ctrl,
  output logic           halt
);

  cpu_pkg::state_e        state, state_next;
  logic [`CPU_SEQ_W-1:0]  seq, seq_next;
  cpu_pkg::mode_e         ir_mode;
  logic [6:0]             ir_op;
  logic [`CPU_REG_AW-1:0] ir_ra, ir_rb, ir_rc;
  logic                   alu_grp;
  logic                   take; // branch condition met

  assign ir_mode = cpu_pkg::mode_e'(ir[31:30]);
  assign ir_ra   = ir[19:16];
  assign ir_rb   = ir[15:12];
  assign ir_rc   = ir[11:8];
  assign halt    = (state == cpu_pkg::ST_HALT);

  always_comb begin
    case (ir_mode)
      cpu_pkg::MODE_REG: ir_op = ir[29:23];
      cpu_pkg::MODE_DIR: ir_op = {1'b0, ir[29:24]};
      default:           ir_op = {3'b000, ir[29:26]};
    endcase
  end

  // rA <= rB op rC in reg mode, rA <= rB op simm in dir mode
  assign alu_grp = ((ir_mode == cpu_pkg::MODE_REG) && ((ir_op & 7'h78) == cpu_pkg::OP_REG_ALU)) ||
                   ((ir_mode == cpu_pkg::MODE_DIR) && (ir_op[6:3] == 4'h0));

  always_comb begin
    case (cpu_pkg::imm_op_e'(ir_op))
      cpu_pkg::OP_BRA:  take = 1'b1;
      cpu_pkg::OP_BEQ:  take = ccr.eq;
      cpu_pkg::OP_BNE:  take = ~ccr.eq;
      cpu_pkg::OP_BGTU: take = ~(ccr.ltu | ccr.eq);
      cpu_pkg::OP_BGT:  take = ~(ccr.lt | ccr.eq);
      cpu_pkg::OP_BGE:  take = ~ccr.lt;
      cpu_pkg::OP_BLE:  take = ccr.lt | ccr.eq;
      cpu_pkg::OP_BLT:  take = ccr.lt;
      cpu_pkg::OP_BGEU: take = ~ccr.ltu;
      cpu_pkg::OP_BLTU: take = ccr.ltu;
      cpu_pkg::OP_BLEU: take = ccr.ltu | ccr.eq;
      default:          take = 1'b0; // brn, ldiu
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= cpu_pkg::ST_FETCH;
      seq   <= '0;
    end else begin
      state <= state_next;
      seq   <= seq_next;
    end
  end

  always_comb begin
    state_next    = state;
    seq_next      = seq;
    ctrl          = '0;
    ctrl.alu_op   = cpu_pkg::ALU_ADD;
    ctrl.rd_addr1 = ir_ra;
    ctrl.rd_addr2 = ir_rb;
    ctrl.wr_addr  = ir_ra;
    case (state)
      cpu_pkg::ST_FETCH: begin
        seq_next = seq + 1'b1;
        case (seq)
          0: begin
            ctrl.bus_read = 1'b1;
            if (bus_wait) seq_next = seq; // hold request until granted
          end
          1: begin
            ctrl.bus_read = 1'b1; // data valid this cycle
            ctrl.ir_write = 1'b1;
          end
          default: begin
            ctrl.pc_sel = cpu_pkg::PC_INC;
            seq_next    = '0;
            state_next  = cpu_pkg::ST_EVAL;
          end
        endcase
      end
      cpu_pkg::ST_EVAL: begin
        state_next = cpu_pkg::ST_FETCH; // single step unless held below
        seq_next   = '0;
        if (alu_grp) begin
          ctrl.alu_op   = cpu_pkg::alu_op_e'(ir_op[2:0]);
          ctrl.rd_addr1 = ir_rb;
          ctrl.rd_addr2 = ir_rc;
          if (ir_mode == cpu_pkg::MODE_DIR) ctrl.alu2_sel = cpu_pkg::A2_SIMM;
          if (seq == 0) begin
            state_next = state; // operate, result registered
            seq_next   = seq + 1'b1;
          end else begin
            ctrl.reg_write = 1'b1;
          end
        end else if (ir_mode == cpu_pkg::MODE_REG) begin
          case (ir_op)
            cpu_pkg::OP_NOP: ;
            cpu_pkg::OP_CMP: begin
              ctrl.alu_op    = cpu_pkg::ALU_SUB;
              ctrl.ccr_write = 1'b1; // flags of rA - rB
            end
            cpu_pkg::OP_MOV: begin
              ctrl.reg_sel   = cpu_pkg::RS_MOVB;
              ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_COM: begin
              ctrl.reg_sel   = cpu_pkg::RS_COMB;
              ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_NEG: begin
              ctrl.reg_sel   = cpu_pkg::RS_NEGB;
              ctrl.reg_write = 1'b1;
            end
            default: state_next = cpu_pkg::ST_HALT;
          endcase
        end else if (ir_mode == cpu_pkg::MODE_IMM) begin
          if (ir_op == cpu_pkg::OP_LDIU) begin
            ctrl.reg_sel   = cpu_pkg::RS_UIMM;
            ctrl.reg_write = 1'b1;
          end else if (ir_op <= cpu_pkg::OP_BRN) begin
            if (take) ctrl.pc_sel = cpu_pkg::PC_REL;
          end else begin
            state_next = cpu_pkg::ST_HALT;
          end
        end else if (ir_mode == cpu_pkg::MODE_REGIND &&
                     (ir_op == cpu_pkg::OP_STL || ir_op == cpu_pkg::OP_LDL)) begin
          ctrl.addr_mar = 1'b1;
          state_next    = state;
          seq_next      = seq + 1'b1;
          case (seq)
            0: begin
              ctrl.rd_addr1 = ir_rb; // effective address rB + simm
              ctrl.alu2_sel = cpu_pkg::A2_SIMM;
            end
            1: begin
              ctrl.mar_sel  = cpu_pkg::MAR_ALU;
              ctrl.mdr_load = (ir_op == cpu_pkg::OP_STL); // mdr <= rA
            end
            2: begin
              ctrl.bus_write = (ir_op == cpu_pkg::OP_STL);
              ctrl.bus_read  = (ir_op == cpu_pkg::OP_LDL);
              if (bus_wait) seq_next = seq;
            end
            3: begin
              if (ir_op == cpu_pkg::OP_STL) begin
                state_next = cpu_pkg::ST_FETCH;
                seq_next   = '0;
              end else begin
                ctrl.bus_read = 1'b1; // read data sampled here
                ctrl.mdr_load = 1'b1;
              end
            end
            default: begin
              ctrl.reg_sel   = cpu_pkg::RS_MDR;
              ctrl.reg_write = 1'b1;
              state_next     = cpu_pkg::ST_FETCH;
              seq_next       = '0;
            end
          endcase
        end else begin
          state_next = cpu_pkg::ST_HALT; // unknown opcode
        end
      end
      default: state_next = cpu_pkg::ST_HALT;
    endcase
  end

  a_bus_excl: assert property (@(posedge clock) disable iff (!reset_n)
    !(ctrl.bus_read && ctrl.bus_write));

  a_state_legal: assert property (@(posedge clock) disable iff (!reset_n)
    state inside {cpu_pkg::ST_FETCH, cpu_pkg::ST_EVAL, cpu_pkg::ST_HALT});

endmodule

// File: hw/cpu_regfile.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpu_regfile (
  input  logic                   clock,
  input  logic                   reset_n,
  input  cpu_pkg::ctrl_t         ctrl,
  input  logic [`CPU_DATA_W-1:0] wr_data,
  output logic [`CPU_DATA_W-1:0] rd_data1,
  output logic [`CPU_DATA_W-1:0] rd_data2
);

  logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_write) begin
      regs[ctrl.wr_addr] <= wr_data;
    end
  end

  // both read ports are combinational
  assign rd_data1 = regs[ctrl.rd_addr1];
  assign rd_data2 = regs[ctrl.rd_addr2];

  // write address comes straight from the decoded ir
  a_wr_addr_known: assert property (@(posedge clock) disable iff (!reset_n)
    ctrl.reg_write |-> !$isunknown(ctrl.wr_addr));

endmodule

// File: hw/cpu_execute.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpu_execute (
  input  logic                   clock,
  input  logic                   reset_n,
  input  cpu_pkg::ctrl_t         ctrl,
  input  logic [31:0]            ir,
  input  logic [`CPU_DATA_W-1:0] rd_data1,
  input  logic [`CPU_DATA_W-1:0] rd_data2,
  input  logic [`CPU_DATA_W-1:0] mdr,
  output logic [`CPU_DATA_W-1:0] alu_out,
  output logic [`CPU_DATA_W-1:0] wr_data,
  output cpu_pkg::ccr_t          ccr
);

  logic [`CPU_DATA_W-1:0] simm, uimm, op2, alu_res;

  assign simm = {{(`CPU_DATA_W-16){ir[23]}}, ir[23:20], ir[11:0]};
  assign uimm = {{(`CPU_DATA_W-16){1'b0}}, ir[23:20], ir[11:0]};
  assign op2  = (ctrl.alu2_sel == cpu_pkg::A2_SIMM) ? simm : rd_data2;

  always_comb begin
    case (ctrl.alu_op)
      cpu_pkg::ALU_AND: alu_res = rd_data1 & op2;
      cpu_pkg::ALU_OR:  alu_res = rd_data1 | op2;
      cpu_pkg::ALU_ADD: alu_res = rd_data1 + op2;
      cpu_pkg::ALU_SUB: alu_res = rd_data1 - op2;
      cpu_pkg::ALU_XOR: alu_res = rd_data1 ^ op2;
      cpu_pkg::ALU_SHL: alu_res = rd_data1 << op2[4:0];
      cpu_pkg::ALU_SHR: alu_res = rd_data1 >> op2[4:0];
      default:          alu_res = $signed(rd_data1) >>> op2[4:0]; // asr
    endcase
  end

  always_ff @(posedge clock) begin
    alu_out <= alu_res; // used one step later for write-back or mar
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      ccr <= '0;
    end else if (ctrl.ccr_write) begin
      ccr.ltu <= rd_data1 < op2;
      ccr.lt  <= $signed(rd_data1) < $signed(op2);
      ccr.eq  <= rd_data1 == op2;
    end
  end

  always_comb begin
    case (ctrl.reg_sel)
      cpu_pkg::RS_MDR:  wr_data = mdr;
      cpu_pkg::RS_MOVB: wr_data = rd_data2;
      cpu_pkg::RS_COMB: wr_data = ~rd_data2;
      cpu_pkg::RS_NEGB: wr_data = -rd_data2;
      cpu_pkg::RS_UIMM: wr_data = uimm;
      default:          wr_data = alu_out;
    endcase
  end

endmodule

// File: hw/cpu_bus_unit.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpu_bus_unit (
  input  logic                   clock,
  input  logic                   reset_n,
  input  cpu_pkg::ctrl_t         ctrl,
  output logic [31:0]            ir,
  input  logic [`CPU_DATA_W-1:0] alu_out,
  input  logic [`CPU_DATA_W-1:0] rd_data1,
  input  logic [`CPU_DATA_W-1:0] bus_rdata,
  output logic [`CPU_DATA_W-1:0] mdr,
  output cpu_pkg::bus_req_t      bus_req
);

  logic [`CPU_DATA_W-1:0] pc, mar, simm;

  assign simm = {{(`CPU_DATA_W-16){ir[23]}}, ir[23:20], ir[11:0]};

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc <= `CPU_RESET_PC;
      ir <= '0;
    end else begin
      case (ctrl.pc_sel)
        cpu_pkg::PC_INC: pc <= pc + `CPU_PC_STEP;
        cpu_pkg::PC_REL: pc <= pc + simm; // pc already past the branch
        default:         pc <= pc;
      endcase
      if (ctrl.ir_write) ir <= bus_rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (ctrl.mar_sel == cpu_pkg::MAR_ALU) mar <= alu_out;
    // bus data for ld.l or rA for st.l
    if (ctrl.mdr_load) mdr <= ctrl.bus_read ? bus_rdata : rd_data1;
  end

  always_comb begin
    bus_req.addr  = ctrl.addr_mar ? mar : pc;
    bus_req.wdata = mdr;
    bus_req.read  = ctrl.bus_read;
    bus_req.write = ctrl.bus_write;
  end

  // a stalled write keeps address and data steady until it completes
  a_write_hold: assert property (@(posedge clock) disable iff (!reset_n)
    bus_req.write && $past(bus_req.write) |->
      $stable(bus_req.addr) && $stable(bus_req.wdata));

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpu_top (
  input  logic                   clock,
  input  logic                   reset_n,
  output cpu_pkg::bus_req_t      bus_req,
  input  logic [`CPU_DATA_W-1:0] bus_rdata,
  input  logic                   bus_wait,
  output logic                   halt
);

  cpu_pkg::ctrl_t         ctrl;
  cpu_pkg::ccr_t          ccr;
  logic [31:0]            ir;
  logic [`CPU_DATA_W-1:0] rd_data1, rd_data2;
  logic [`CPU_DATA_W-1:0] wr_data, alu_out, mdr;

  cpu_control u_control (
    .clock, .reset_n, .ir, .ccr, .bus_wait, .ctrl, .halt
  );

  cpu_regfile u_regfile (
    .clock, .reset_n, .ctrl, .wr_data, .rd_data1, .rd_data2
  );

  cpu_execute u_execute (
    .clock,
    .reset_n,
    .ctrl,
    .ir,
    .rd_data1,
    .rd_data2,
    .mdr,
    .alu_out,
    .wr_data,
    .ccr
  );

  // pc, ir, mar and mdr plus the outside bus request
  cpu_bus_unit u_bus_unit (
    .clock, .reset_n, .ctrl, .ir, .alu_out, .rd_data1, .bus_rdata, .mdr, .bus_req
  );

endmodule

// File: verif/cpu_checker.sv
`timescale 1ns/10ps

module cpu_checker (
  input  logic              clock,
  input  logic              reset_n,
  input  cpu_pkg::bus_req_t bus_req,
  input  logic              bus_wait,
  input  logic              halt,
  output bit                done,
  output int                value_errors,
  output int                other_errors,
  output int                stores_seen,
  output int                stores_expected
);

  localparam int RESET_TIMEOUT = 100;
  localparam int HALT_TIMEOUT  = 5000;
  localparam int QUIET_CYCLES  = 20;

  logic [31:0] img [256]; // model copy of memory
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];

  function automatic logic [31:0] alu_ref(input logic [2:0] op, input logic [31:0] a, b);
    case (op)
      3'd0:    return a & b;
      3'd1:    return a | b;
      3'd2:    return a + b;
      3'd3:    return a - b;
      3'd4:    return a ^ b;
      3'd5:    return a << b[4:0];
      3'd6:    return a >> b[4:0];
      default: return $signed(a) >>> b[4:0];
    endcase
  endfunction

  function automatic logic branch_taken(input logic [3:0] op, input logic ltu, lt, eq);
    case (op)
      4'h0:    return 1'b1;      // bra
      4'h1:    return eq;
      4'h2:    return !eq;
      4'h3:    return !ltu && !eq; // bgtu
      4'h4:    return !lt && !eq;
      4'h5:    return !lt;
      4'h6:    return lt || eq;
      4'h7:    return lt;
      4'h8:    return !ltu;
      4'h9:    return ltu;
      4'ha:    return ltu || eq;
      default: return 1'b0;      // brn
    endcase
  endfunction

  // runs the program image and records every store in order
  function automatic void build_expected();
    logic [31:0] r [16];
    logic [31:0] pc, ins, simm, ea;
    logic [3:0]  ra, rb, rc;
    logic        ltu, lt, eq, running;
    int          steps;
    for (int i = 0; i < 256; i++) img[i] = cpu_tb.mem[i];
    for (int i = 0; i < 16; i++) r[i] = '0;
    pc      = '0;
    ltu     = 1'b0;
    lt      = 1'b0;
    eq      = 1'b0;
    running = 1'b1;
    steps   = 0;
    while (running && steps < 1000) begin
      ins  = img[pc[9:2]];
      pc   = pc + 32'd4; // branches are relative to this
      steps++;
      ra   = ins[19:16];
      rb   = ins[15:12];
      rc   = ins[11:8];
      simm = {{16{ins[23]}}, ins[23:20], ins[11:0]};
      case (ins[31:30])
        2'd0: begin
          if (ins[29:26] == 4'b0100) r[ra] = alu_ref(ins[25:23], r[rb], r[rc]);
          else if (ins[29:23] == 7'h09) begin
            ltu = r[ra] < r[rb];
            lt  = $signed(r[ra]) < $signed(r[rb]);
            eq  = r[ra] == r[rb];
          end
          else if (ins[29:23] == 7'h0a) r[ra] = r[rb];
          else if (ins[29:23] == 7'h0b) r[ra] = ~r[rb];
          else if (ins[29:23] == 7'h0c) r[ra] = -r[rb];
          else if (ins[29:23] != 7'h00) running = 1'b0;
        end
        2'd3: begin
          if (ins[29:27] == 3'd0) r[ra] = alu_ref(ins[26:24], r[rb], simm);
          else running = 1'b0;
        end
        2'd2: begin
          if (ins[29:26] == 4'hc) r[ra] = {16'h0, ins[23:20], ins[11:0]}; // ldiu
          else if (ins[29:26] > 4'hb) running = 1'b0;
          else if (branch_taken(ins[29:26], ltu, lt, eq)) pc = pc + simm;
        end
        default: begin
          ea = r[rb] + simm;
          if (ins[29:26] == 4'h0) begin
            exp_addr.push_back(ea);
            exp_data.push_back(r[ra]);
            img[ea[9:2]] = r[ra];
          end else if (ins[29:26] == 4'h1) begin
            r[ra] = img[ea[9:2]];
          end else begin
            running = 1'b0;
          end
        end
      endcase
    end
  endfunction

  // a write completes on a rising edge with wait low
  always @(posedge clock) begin : compare_writes
    logic [31:0] want_addr, want_data;
    if (reset_n && bus_req.write && !bus_wait) begin
      stores_seen++;
      if (halt) begin
        value_errors++;
        $display("** Error @ %0t: bus write to %h after halt", $time, bus_req.addr);
      end else if (exp_addr.size() == 0) begin
        value_errors++;
        $display("** Error @ %0t: unexpected store of %h to %h", $time, bus_req.wdata,
                 bus_req.addr);
      end else begin
        want_addr = exp_addr.pop_front();
        want_data = exp_data.pop_front();
        if (bus_req.addr !== want_addr || bus_req.wdata !== want_data) begin
          value_errors++;
          $display("** Error @ %0t: store %h to %h, expected %h to %h", $time,
                   bus_req.wdata, bus_req.addr, want_data, want_addr);
        end
      end
    end
  end

  initial begin : end_of_run
    int cycles;
    cycles = 0;
    while (!reset_n && cycles < RESET_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (!reset_n) begin
      $display("timeout: reset was never released");
      other_errors++;
    end
    build_expected();
    stores_expected = exp_addr.size();
    cycles = 0;
    while (!halt && cycles < HALT_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (!halt) begin
      $display("timeout: halt did not rise within %0d cycles", HALT_TIMEOUT);
      other_errors++;
    end
    repeat (QUIET_CYCLES) @(negedge clock); // bus stays idle after halt
    if (stores_seen != stores_expected) begin
      $display("store count wrong: %0d seen, %0d expected", stores_seen, stores_expected);
      other_errors++;
    end
    done = 1'b1;
  end

endmodule

// File: verif/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

  localparam int DONE_TIMEOUT = 8000; // cycles

  logic              clock = 1'b0;
  logic              reset_n = 1'b0;
  logic [31:0]       bus_rdata = '0;
  logic              bus_wait = 1'b1;
  logic              halt;
  cpu_pkg::bus_req_t bus_req;

  logic [31:0] mem [256]; // word memory indexed by addr[9:2]
  integer      seed = 32'h3328_8e37;
  int          pc_w, slot, wait_left;
  logic        in_xfer = 1'b0;
  logic        data_phase = 1'b0; // cycle after a read completed

  bit check_done;
  int value_errors, other_errors, stores_seen, stores_expected;

  always #10 clock = ~clock;

  cpu_top DUT (.clock, .reset_n, .bus_req, .bus_rdata, .bus_wait, .halt);

  cpu_checker u_checker (
    .clock, .reset_n, .bus_req, .bus_wait, .halt, .done(check_done),
    .value_errors, .other_errors, .stores_seen, .stores_expected
  );

  function automatic logic [31:0] reg_form(input logic [6:0] op, input logic [3:0] ra, rb, rc);
    return {2'd0, op, 3'd0, ra, rb, rc, 8'd0};
  endfunction

  // imm and reg-indirect modes share one layout
  function automatic logic [31:0] imm_form(input logic [1:0] mode, input logic [3:0] op, ra, rb,
                                           input logic [15:0] imm);
    return {mode, op, 2'd0, imm[15:12], ra, rb, imm[11:0]};
  endfunction

  function automatic logic [31:0] dir_form(input logic [2:0] op, input logic [3:0] ra, rb,
                                           input logic [15:0] imm);
    return {2'd3, 3'd0, op, imm[15:12], ra, rb, imm[11:0]};
  endfunction

  function automatic logic [3:0] pick_operand();
    return 4'(1 + $unsigned($random(seed)) % 10); // one of r1..r10
  endfunction

  task automatic emit(input logic [31:0] word);
    mem[pc_w] = word;
    pc_w++;
  endtask

  // st.l of ra into the next slot above 0x200 (r15 holds 0x280)
  task automatic store_reg(input logic [3:0] ra);
    emit(imm_form(2'd1, 4'h0, ra, 4'd15, 16'(4 * slot - 128)));
    slot++;
  endtask

  task automatic build_program();
    logic [3:0] ra, rb;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5a00_0000 | (i << 2); // fill tagged by address
    end
    pc_w = 0;
    slot = 0;
    for (int r = 1; r <= 8; r++) begin
      emit(imm_form(2'd2, 4'hc, 4'(r), 4'd0, 16'($random(seed)))); // ldiu
    end
    emit(imm_form(2'd2, 4'hc, 4'd15, 4'd0, 16'h0280)); // store base
    emit(reg_form(7'h0b, 4'd9, 4'd1, 4'd0));  // com r9, r1
    emit(reg_form(7'h0c, 4'd10, 4'd2, 4'd0)); // neg r10, r2 for negative operands
    for (int op = 0; op < 8; op++) begin
      emit(reg_form({4'b0100, 3'(op)}, 4'd11, pick_operand(), pick_operand()));
      store_reg(4'd11);
      emit(dir_form(3'(op), 4'd11, pick_operand(), 16'($random(seed))));
      store_reg(4'd11);
    end
    for (int op = 10; op <= 12; op++) begin // mov, com, neg
      emit(reg_form(7'(op), 4'd12, pick_operand(), 4'd0));
      store_reg(4'd12);
    end
    emit(imm_form(2'd2, 4'hc, 4'd13, 4'd0, 16'hbad0)); // marker value
    for (int op = 0; op < 12; op++) begin
      ra = pick_operand();
      rb = (op % 3 == 0) ? ra : pick_operand(); // some compares are equal
      emit(reg_form(7'h09, ra, rb, 4'd0));
      emit(imm_form(2'd2, 4'(op), 4'd0, 4'd0, 16'h0004)); // skips the marker
      store_reg(4'd13);
    end
    for (int i = 0; i < 4; i++) begin
      emit(imm_form(2'd1, 4'h1, 4'd14, 4'd15, 16'(4 * ($unsigned($random(seed)) % 19) - 128)));
      store_reg(4'd14);
    end
    emit(reg_form(7'h7f, 4'd0, 4'd0, 4'd0)); // opcode outside the set
    store_reg(4'd11); // never reached
  endtask

  // memory with 0 to 2 wait cycles per transfer
  always @(negedge clock) begin : memory_model
    if (!reset_n) begin
      bus_wait   <= 1'b1;
      in_xfer    = 1'b0;
      data_phase = 1'b0;
    end else if (data_phase) begin
      bus_wait   <= 1'b0; // rdata still held
      data_phase = 1'b0;
    end else if (bus_req.read || bus_req.write) begin
      if (!in_xfer) begin
        in_xfer   = 1'b1;
        wait_left = $unsigned($random(seed)) % 3;
      end
      if (wait_left > 0) begin
        bus_wait <= 1'b1;
        wait_left--;
      end else begin
        bus_wait <= 1'b0;
        in_xfer  = 1'b0;
        if (bus_req.write) begin
          mem[bus_req.addr[9:2]] = bus_req.wdata;
        end else begin
          bus_rdata  <= mem[bus_req.addr[9:2]];
          data_phase = 1'b1;
        end
      end
    end else begin
      bus_wait <= 1'b0;
    end
  end

  initial begin : run
    int cycles;
    int timeouts;
    timeouts = 0;
    build_program();
    repeat (10) @(negedge clock);
    reset_n <= 1'b1;
    cycles = 0;
    while (!check_done && cycles < DONE_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (!check_done) begin
      $display("timeout: the checker did not finish within %0d cycles", DONE_TIMEOUT);
      timeouts++;
    end
    $display("errors: %0d value, %0d other, %0d timeout; stores seen %0d of %0d",
             value_errors, other_errors, timeouts, stores_seen, stores_expected);
    if (value_errors + other_errors + timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_control.sv
hw/cpu_regfile.sv
hw/cpu_execute.sv
hw/cpu_bus_unit.sv
hw/cpu_top.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = cpu_tb
FILELIST  = all.f
LOG       = sim.log
FAIL_MSG  = TESTBENCH FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
